//--- design/core_pkg.sv
`default_nettype none

package core_pkg;

  localparam int CMT_ID_W = 6;
  localparam int RNID_W   = 6;
  localparam int PADDR_W  = 32;
  localparam int DATA_W   = 32;

  // Younger-than window is half the id space
  localparam int CMT_ID_HALF = 2 ** (CMT_ID_W - 1);

  typedef logic [CMT_ID_W-1:0] cmt_id_t;  // Program-order id from commit
  typedef logic [RNID_W-1:0]   rnid_t;    // Renamed register tag
  typedef logic [PADDR_W-1:0]  paddr_t;
  typedef logic [DATA_W-1:0]   data_t;

  // E is younger than R when (E - R) mod 64 falls in 1..31
  function automatic logic is_younger(input cmt_id_t i_entry_id,
                                      input cmt_id_t i_ref_id);
    cmt_id_t diff;
    diff = i_entry_id - i_ref_id;
    return (diff != '0) && (int'(diff) < CMT_ID_HALF);
  endfunction

endpackage

`default_nettype wire

//--- design/stq_pkg.sv
`default_nettype none

package stq_pkg;

  import core_pkg::*;

  typedef enum logic [2:0] {
    STQ_INIT         = 3'd0,  // Dispatched, waiting for address issue
    STQ_TLB_HAZ      = 3'd1,
    STQ_WAIT_ST_DATA = 3'd2,
    STQ_READY        = 3'd3,  // Asking for rerun
    STQ_DONE         = 3'd4,
    STQ_COMMIT       = 3'd5   // Waiting for L1D write
  } stq_state_t;

  // What the controller sees of one entry
  typedef struct packed {
    logic       valid;
    stq_state_t state;
    cmt_id_t    cmt_id;
    paddr_t     paddr;
    data_t      data;
  } stq_summary_t;

endpackage

`default_nettype wire

//--- design/stq_entry_if.sv
`timescale 1ns/1ps
`default_nettype none

interface stq_entry_if
  import stq_pkg::*;
  ();

  stq_summary_t summary;

  logic drain_done;    // Head write accepted by L1D
  logic rerun_accept;  // Rerun granted to this entry

  modport entry (
    output summary,
    input  drain_done,
    input  rerun_accept
  );

  modport ctrl (
    input  summary,
    output drain_done,
    output rerun_accept
  );

endinterface

`default_nettype wire

//--- design/stq_entry.sv
`timescale 1ns/1ps
`default_nettype none

module stq_entry
  import core_pkg::*;
  import stq_pkg::*;
#(
  parameter int STQ_ENTRIES = 4,
  parameter int ENTRY_ID    = 0
) (
  input  logic                           i_clk,
  input  logic                           i_reset_n,

  input  logic                           i_disp_load,
  input  logic [$clog2(STQ_ENTRIES)-1:0] i_disp_index,
  input  cmt_id_t                        i_disp_cmt_id,
  input  rnid_t                          i_disp_rnid,
  input  logic                           i_disp_data_ready,

  input  logic                           i_ex1_valid,
  input  logic [$clog2(STQ_ENTRIES)-1:0] i_ex1_index,
  input  logic                           i_ex1_hazard,
  input  paddr_t                         i_ex1_paddr,
  input  logic                           i_ex1_data_valid,
  input  data_t                          i_ex1_data,

  input  logic                           i_wb_valid,
  input  rnid_t                          i_wb_rnid,
  input  data_t                          i_wb_data,

  input  logic                           i_tlb_resolve,

  input  logic                           i_commit_valid,
  input  logic                           i_commit_flush,
  input  cmt_id_t                        i_commit_cmt_id,

  stq_entry_if.entry                     io_entry
);

  localparam int IDX_W = $clog2(STQ_ENTRIES);
  localparam logic [IDX_W-1:0] MY_IDX = IDX_W'(ENTRY_ID);

  logic       r_valid;
  stq_state_t r_state;
  logic       r_data_ready;   // Store data held in r_data
  logic       r_tag_pending;  // Source register not yet written back
  cmt_id_t    r_cmt_id;
  rnid_t      r_rnid;
  paddr_t     r_paddr;
  data_t      r_data;

  logic w_disp_sel;
  logic w_ex1_sel;
  logic w_wb_hit;
  logic w_flush_kill;
  logic w_ex1_has_data;

  assign w_disp_sel = i_disp_load && (i_disp_index == MY_IDX);

  assign w_ex1_sel = r_valid && i_ex1_valid && (i_ex1_index == MY_IDX) &&
                     (r_state == STQ_INIT);

  // Snoop write-back only while the source is outstanding
  assign w_wb_hit = r_valid && i_wb_valid && r_tag_pending && !r_data_ready &&
                    (i_wb_rnid == r_rnid) &&
                    ((r_state == STQ_INIT) || (r_state == STQ_WAIT_ST_DATA));

  assign w_flush_kill = r_valid && i_commit_valid && i_commit_flush &&
                        is_younger(r_cmt_id, i_commit_cmt_id);

  assign w_ex1_has_data = i_ex1_data_valid || r_data_ready;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid       <= 1'b0;
      r_state       <= STQ_INIT;
      r_data_ready  <= 1'b0;
      r_tag_pending <= 1'b0;
    end else if (w_flush_kill) begin
      r_valid <= 1'b0;
      r_state <= STQ_INIT;
    end else if (w_disp_sel) begin
      r_valid       <= 1'b1;
      r_state       <= STQ_INIT;
      r_data_ready  <= 1'b0;
      r_tag_pending <= !i_disp_data_ready;
    end else if (r_valid) begin
      if (w_wb_hit) begin
        r_data_ready  <= 1'b1;
        r_tag_pending <= 1'b0;
      end
      case (r_state)
        STQ_INIT: begin
          if (w_ex1_sel) begin
            if (i_ex1_data_valid) begin
              r_data_ready  <= 1'b1;
              r_tag_pending <= 1'b0;
            end
            if (i_ex1_hazard) begin
              r_state <= STQ_TLB_HAZ;
            end else if (w_ex1_has_data) begin
              r_state <= STQ_DONE;
            end else begin
              r_state <= STQ_WAIT_ST_DATA;
            end
          end
        end
        STQ_TLB_HAZ: begin
          if (i_tlb_resolve) begin
            r_state <= STQ_READY;
          end
        end
        STQ_WAIT_ST_DATA: begin
          if (r_data_ready) begin
            r_state <= STQ_DONE;  // One cycle after capture
          end
        end
        STQ_READY: begin
          if (io_entry.rerun_accept) begin
            r_state <= STQ_INIT;
          end
        end
        STQ_DONE: begin
          if (i_commit_valid && (i_commit_cmt_id == r_cmt_id)) begin
            r_state <= STQ_COMMIT;
          end
        end
        STQ_COMMIT: begin
          if (io_entry.drain_done) begin
            r_valid <= 1'b0;
            r_state <= STQ_INIT;
          end
        end
        default: r_state <= STQ_INIT;
      endcase
    end
  end

  // Payload
  always_ff @(posedge i_clk) begin
    if (w_disp_sel) begin
      r_cmt_id <= i_disp_cmt_id;
      r_rnid   <= i_disp_rnid;
    end
    if (w_ex1_sel) begin
      r_paddr <= i_ex1_paddr;
    end
    if (w_ex1_sel && i_ex1_data_valid) begin
      r_data <= i_ex1_data;  // EX1 data wins over same-cycle broadcast
    end else if (w_wb_hit) begin
      r_data <= i_wb_data;
    end
  end

  always_comb begin
    io_entry.summary.valid  = r_valid;
    io_entry.summary.state  = r_state;
    io_entry.summary.cmt_id = r_cmt_id;
    io_entry.summary.paddr  = r_paddr;
    io_entry.summary.data   = r_data;
  end

endmodule

`default_nettype wire

//--- design/stq_order_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module stq_order_ctrl
  import core_pkg::*;
  import stq_pkg::*;
#(
  parameter int STQ_ENTRIES = 4
) (
  input  logic                           i_clk,
  input  logic                           i_reset_n,

  input  logic                           i_disp_valid,
  output logic                           o_disp_accept,
  output logic [$clog2(STQ_ENTRIES)-1:0] o_disp_index,
  output logic                           o_full,

  output logic                           o_l1d_wr_valid,
  output paddr_t                         o_l1d_wr_paddr,
  output data_t                          o_l1d_wr_data,
  input  logic                           i_l1d_wr_conflict,

  output logic                           o_rerun_valid,
  output logic [$clog2(STQ_ENTRIES)-1:0] o_rerun_index,
  input  logic                           i_rerun_accept,

  stq_entry_if.ctrl                      io_entries [STQ_ENTRIES]
);

  localparam int IDX_W = $clog2(STQ_ENTRIES);

  logic [IDX_W-1:0] r_head;
  logic [IDX_W:0]   w_count;
  logic             w_drain_hit;
  stq_summary_t     w_sum [STQ_ENTRIES];

  for (genvar g = 0; g < STQ_ENTRIES; g++) begin : g_ent
    assign w_sum[g] = io_entries[g].summary;
    assign io_entries[g].drain_done = w_drain_hit && (r_head == IDX_W'(g));
    assign io_entries[g].rerun_accept = i_rerun_accept && o_rerun_valid &&
                                        (o_rerun_index == IDX_W'(g));
  end

  // Live entries are contiguous from head
  always_comb begin
    w_count = '0;
    for (int i = 0; i < STQ_ENTRIES; i++) begin
      w_count = w_count + (IDX_W + 1)'(w_sum[i].valid);
    end
  end

  assign o_full        = (w_count == (IDX_W + 1)'(STQ_ENTRIES));
  assign o_disp_index  = r_head + w_count[IDX_W-1:0];
  assign o_disp_accept = i_disp_valid && !o_full;

  assign o_l1d_wr_valid = w_sum[r_head].valid && (w_sum[r_head].state == STQ_COMMIT);
  assign o_l1d_wr_paddr = w_sum[r_head].paddr;
  assign o_l1d_wr_data  = w_sum[r_head].data;
  assign w_drain_hit    = o_l1d_wr_valid && !i_l1d_wr_conflict;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head <= '0;
    end else if (w_drain_hit) begin
      r_head <= r_head + IDX_W'(1);
    end
  end

  // Oldest READY entry, scanning from head
  always_comb begin
    logic [IDX_W-1:0] scan_idx;
    o_rerun_valid = 1'b0;
    o_rerun_index = r_head;
    for (int i = 0; i < STQ_ENTRIES; i++) begin
      scan_idx = r_head + IDX_W'(i);
      if (!o_rerun_valid && w_sum[scan_idx].valid &&
          (w_sum[scan_idx].state == STQ_READY)) begin
        o_rerun_valid = 1'b1;
        o_rerun_index = scan_idx;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/store_queue.sv
`timescale 1ns/1ps
`default_nettype none

module store_queue
  import core_pkg::*;
#(
  parameter int STQ_ENTRIES = 4
) (
  input  logic                           i_clk,
  input  logic                           i_reset_n,

  input  logic                           i_disp_valid,
  input  cmt_id_t                        i_disp_cmt_id,
  input  rnid_t                          i_disp_rnid,
  input  logic                           i_disp_data_ready,
  output logic [$clog2(STQ_ENTRIES)-1:0] o_disp_index,
  output logic                           o_full,

  input  logic                           i_ex1_valid,
  input  logic [$clog2(STQ_ENTRIES)-1:0] i_ex1_index,
  input  logic                           i_ex1_hazard,
  input  paddr_t                         i_ex1_paddr,
  input  logic                           i_ex1_data_valid,
  input  data_t                          i_ex1_data,

  input  logic                           i_wb_valid,
  input  rnid_t                          i_wb_rnid,
  input  data_t                          i_wb_data,

  input  logic                           i_tlb_resolve,

  input  logic                           i_commit_valid,
  input  logic                           i_commit_flush,
  input  cmt_id_t                        i_commit_cmt_id,

  output logic                           o_l1d_wr_valid,
  output paddr_t                         o_l1d_wr_paddr,
  output data_t                          o_l1d_wr_data,
  input  logic                           i_l1d_wr_conflict,

  output logic                           o_rerun_valid,
  output logic [$clog2(STQ_ENTRIES)-1:0] o_rerun_index,
  input  logic                           i_rerun_accept
);

  logic w_disp_load;

  stq_entry_if u_entry_if [STQ_ENTRIES] ();

  stq_order_ctrl #(
    .STQ_ENTRIES (STQ_ENTRIES)
  ) u_order_ctrl (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_disp_valid      (i_disp_valid),
    .o_disp_accept     (w_disp_load),
    .o_disp_index      (o_disp_index),
    .o_full            (o_full),
    .o_l1d_wr_valid    (o_l1d_wr_valid),
    .o_l1d_wr_paddr    (o_l1d_wr_paddr),
    .o_l1d_wr_data     (o_l1d_wr_data),
    .i_l1d_wr_conflict (i_l1d_wr_conflict),
    .o_rerun_valid     (o_rerun_valid),
    .o_rerun_index     (o_rerun_index),
    .i_rerun_accept    (i_rerun_accept),
    .io_entries        (u_entry_if)
  );

  for (genvar g = 0; g < STQ_ENTRIES; g++) begin : g_entry
    stq_entry #(
      .STQ_ENTRIES (STQ_ENTRIES),
      .ENTRY_ID    (g)
    ) u_entry (
      .i_clk             (i_clk),
      .i_reset_n         (i_reset_n),
      .i_disp_load       (w_disp_load),
      .i_disp_index      (o_disp_index),  // Tail from the controller
      .i_disp_cmt_id     (i_disp_cmt_id),
      .i_disp_rnid       (i_disp_rnid),
      .i_disp_data_ready (i_disp_data_ready),
      .i_ex1_valid       (i_ex1_valid),
      .i_ex1_index       (i_ex1_index),
      .i_ex1_hazard      (i_ex1_hazard),
      .i_ex1_paddr       (i_ex1_paddr),
      .i_ex1_data_valid  (i_ex1_data_valid),
      .i_ex1_data        (i_ex1_data),
      .i_wb_valid        (i_wb_valid),
      .i_wb_rnid         (i_wb_rnid),
      .i_wb_data         (i_wb_data),
      .i_tlb_resolve     (i_tlb_resolve),
      .i_commit_valid    (i_commit_valid),
      .i_commit_flush    (i_commit_flush),
      .i_commit_cmt_id   (i_commit_cmt_id),
      .io_entry          (u_entry_if[g])
    );
  end

endmodule

`default_nettype wire

//--- sim/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 2
) (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  initial begin
    o_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #1 o_reset_n = 1'b1;  // Release just after the edge
  end

endmodule

`default_nettype wire

//--- sim/tb_store_queue.sv
`timescale 1ns/1ps
`default_nettype none

module tb_store_queue;

  localparam int STQ_ENTRIES = 4;
  localparam int IDX_W       = 2;
  localparam int WAIT_LIMIT  = 50;

  // Model states
  localparam int S_INIT   = 0;
  localparam int S_TLB    = 1;
  localparam int S_WAIT   = 2;
  localparam int S_READY  = 3;
  localparam int S_DONE   = 4;
  localparam int S_COMMIT = 5;

  logic             clk, reset_n;
  logic             disp_valid, disp_data_ready, full;
  logic [5:0]       disp_cmt_id, disp_rnid, wb_rnid, commit_cmt_id;
  logic [IDX_W-1:0] disp_index, ex1_index, rerun_index;
  logic             ex1_valid, ex1_hazard, ex1_data_valid;
  logic [31:0]      ex1_paddr, ex1_data, wb_data, l1d_wr_paddr, l1d_wr_data;
  logic             wb_valid, tlb_resolve, commit_valid, commit_flush;
  logic             l1d_wr_valid, l1d_wr_conflict, rerun_valid, rerun_accept;

  logic        m_valid    [STQ_ENTRIES];
  int          m_state    [STQ_ENTRIES];
  logic [5:0]  m_cmt      [STQ_ENTRIES];
  logic [5:0]  m_rnid     [STQ_ENTRIES];
  logic        m_pending  [STQ_ENTRIES];  // Source tag not written back yet
  logic        m_has_data [STQ_ENTRIES];
  logic [31:0] m_paddr    [STQ_ENTRIES];
  logic [31:0] m_data     [STQ_ENTRIES];
  logic        m_promote  [STQ_ENTRIES];  // WAIT entry with data goes DONE next edge
  int          m_head;

  integer      seed;
  logic        rand_conflict;
  int          fd, cnt, idx;
  logic        accepted;
  string       op, line;
  logic [31:0] a0, a1, a2, a3, a4;

  tb_clk_gen #(.PERIOD_NS(100), .RESET_CYCLES(2)) u_clk_gen (.o_clk(clk), .o_reset_n(reset_n));

  store_queue #(.STQ_ENTRIES(STQ_ENTRIES)) store_queue_i (
    .i_clk(clk), .i_reset_n(reset_n),
    .i_disp_valid(disp_valid), .i_disp_cmt_id(disp_cmt_id), .i_disp_rnid(disp_rnid),
    .i_disp_data_ready(disp_data_ready), .o_disp_index(disp_index), .o_full(full),
    .i_ex1_valid(ex1_valid), .i_ex1_index(ex1_index), .i_ex1_hazard(ex1_hazard),
    .i_ex1_paddr(ex1_paddr), .i_ex1_data_valid(ex1_data_valid), .i_ex1_data(ex1_data),
    .i_wb_valid(wb_valid), .i_wb_rnid(wb_rnid), .i_wb_data(wb_data),
    .i_tlb_resolve(tlb_resolve),
    .i_commit_valid(commit_valid), .i_commit_flush(commit_flush),
    .i_commit_cmt_id(commit_cmt_id),
    .o_l1d_wr_valid(l1d_wr_valid), .o_l1d_wr_paddr(l1d_wr_paddr),
    .o_l1d_wr_data(l1d_wr_data), .i_l1d_wr_conflict(l1d_wr_conflict),
    .o_rerun_valid(rerun_valid), .o_rerun_index(rerun_index), .i_rerun_accept(rerun_accept)
  );

  // Younger when (e - r) mod 64 lies in 1..31
  function automatic logic younger_than(input logic [5:0] e, input logic [5:0] r);
    logic [5:0] d;
    d = e - r;
    return (d >= 6'd1) && (d <= 6'd31);
  endfunction

  function automatic int live_count();
    int n;
    n = 0;
    for (int i = 0; i < STQ_ENTRIES; i++) begin
      if (m_valid[i]) n++;
    end
    return n;
  endfunction

  function automatic int model_rerun();
    int pick;
    int j;
    pick = -1;
    for (int i = 0; i < STQ_ENTRIES; i++) begin
      j = (m_head + i) % STQ_ENTRIES;
      if (pick < 0 && m_valid[j] && m_state[j] == S_READY) pick = j;
    end
    return pick;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      fail_run($sformatf("Error at time %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_outputs();
    logic exp_wr;
    exp_wr = m_valid[m_head] && (m_state[m_head] == S_COMMIT);
    check_value(32'(l1d_wr_valid), 32'(exp_wr), "o_l1d_wr_valid");
    check_value(32'(full), 32'(live_count() == STQ_ENTRIES), "o_full");
    check_value(32'(disp_index), 32'((m_head + live_count()) % STQ_ENTRIES), "o_disp_index");
    check_value(32'(rerun_valid), 32'(model_rerun() >= 0), "o_rerun_valid");
  endtask

  task automatic next_cycle();
    for (int i = 0; i < STQ_ENTRIES; i++) begin
      if (m_promote[i] && m_valid[i] && m_state[i] == S_WAIT) m_state[i] = S_DONE;
    end
    @(posedge clk);
    #1;
    disp_valid      = 1'b0;
    ex1_valid       = 1'b0;
    wb_valid        = 1'b0;
    tlb_resolve     = 1'b0;
    commit_valid    = 1'b0;
    commit_flush    = 1'b0;
    rerun_accept    = 1'b0;
    l1d_wr_conflict = 1'b1;  // L1D port busy outside DRAIN
    check_outputs();
    for (int i = 0; i < STQ_ENTRIES; i++) begin
      m_promote[i] = m_valid[i] && (m_state[i] == S_WAIT) && m_has_data[i];
    end
  endtask

  initial begin
    {disp_valid, disp_data_ready, ex1_valid, ex1_hazard, ex1_data_valid} = '0;
    {wb_valid, tlb_resolve, commit_valid, commit_flush, rerun_accept} = '0;
    {disp_cmt_id, disp_rnid, wb_rnid, commit_cmt_id, ex1_index} = '0;
    {ex1_paddr, ex1_data, wb_data} = '0;
    l1d_wr_conflict = 1'b1;
    seed = 86;
    rand_conflict = 1'b0;
    m_head = 0;
    for (int i = 0; i < STQ_ENTRIES; i++) begin
      m_valid[i] = 1'b0;
      m_state[i] = S_INIT;
      m_pending[i] = 1'b0;
      m_has_data[i] = 1'b0;
      m_promote[i] = 1'b0;
    end
    fd = $fopen("sim/store_queue_stim.txt", "r");
    if (fd == 0) fail_run("Cannot open stimulus file sim/store_queue_stim.txt");
    cnt = 0;
    while (reset_n !== 1'b1) begin
      if (cnt == 10) fail_run("Reset was never released");
      @(posedge clk);
      cnt++;
    end
    next_cycle();

    while ($fscanf(fd, "%s", op) == 1) begin
      if (op.substr(0, 0) == "#") begin
        void'($fgets(line, fd));
      end else begin
        case (op)
          "DISP": begin
            if ($fscanf(fd, "%h %h %h %h %h", a0, a1, a2, a3, a4) != 5) begin
              fail_run("Short DISP line");
            end
            check_value(32'(disp_index), a3, "o_disp_index before dispatch");
            check_value(32'(full), a4, "o_full before dispatch");
            disp_valid      = 1'b1;
            disp_cmt_id     = a0[5:0];
            disp_rnid       = a1[5:0];
            disp_data_ready = a2[0];
            if (live_count() < STQ_ENTRIES) begin
              idx = (m_head + live_count()) % STQ_ENTRIES;
              m_valid[idx]    = 1'b1;
              m_state[idx]    = S_INIT;
              m_cmt[idx]      = a0[5:0];
              m_rnid[idx]     = a1[5:0];
              m_pending[idx]  = !a2[0];
              m_has_data[idx] = 1'b0;
            end
            next_cycle();
          end
          "EX1": begin
            if ($fscanf(fd, "%h %h %h %h %h", a0, a1, a2, a3, a4) != 5) begin
              fail_run("Short EX1 line");
            end
            ex1_valid      = 1'b1;
            ex1_index      = a0[IDX_W-1:0];
            ex1_hazard     = a1[0];
            ex1_paddr      = a2;
            ex1_data_valid = a3[0];
            ex1_data       = a4;
            idx = int'(a0[IDX_W-1:0]);
            if (m_valid[idx] && m_state[idx] == S_INIT) begin
              m_paddr[idx] = a2;
              if (a3[0]) begin
                m_data[idx]     = a4;
                m_has_data[idx] = 1'b1;
                m_pending[idx]  = 1'b0;
              end
              if (a1[0]) m_state[idx] = S_TLB;
              else if (m_has_data[idx]) m_state[idx] = S_DONE;
              else m_state[idx] = S_WAIT;
            end
            next_cycle();
          end
          "WB": begin
            if ($fscanf(fd, "%h %h", a0, a1) != 2) fail_run("Short WB line");
            wb_valid = 1'b1;
            wb_rnid  = a0[5:0];
            wb_data  = a1;
            for (int i = 0; i < STQ_ENTRIES; i++) begin
              if (m_valid[i] && m_pending[i] && m_rnid[i] == a0[5:0] &&
                  (m_state[i] == S_INIT || m_state[i] == S_WAIT)) begin
                m_data[i]     = a1;
                m_has_data[i] = 1'b1;
                m_pending[i]  = 1'b0;
              end
            end
            next_cycle();
          end
          "TLB": begin
            tlb_resolve = 1'b1;
            for (int i = 0; i < STQ_ENTRIES; i++) begin
              if (m_valid[i] && m_state[i] == S_TLB) m_state[i] = S_READY;
            end
            next_cycle();
          end
          "RERUN": begin
            if ($fscanf(fd, "%h", a0) != 1) fail_run("Short RERUN line");
            cnt = 0;
            while (!rerun_valid) begin
              if (cnt == WAIT_LIMIT) fail_run("Timed out waiting for a rerun request");
              next_cycle();
              cnt++;
            end
            idx = model_rerun();
            check_value(32'(rerun_index), a0, "o_rerun_index");
            check_value(32'(rerun_index), 32'(idx), "o_rerun_index against model");
            rerun_accept = 1'b1;
            m_state[idx] = S_INIT;
            next_cycle();
          end
          "COMMIT", "FLUSH": begin
            if ($fscanf(fd, "%h", a0) != 1) fail_run("Short COMMIT or FLUSH line");
            commit_valid  = 1'b1;
            commit_flush  = (op == "FLUSH");
            commit_cmt_id = a0[5:0];
            for (int i = 0; i < STQ_ENTRIES; i++) begin
              if (m_valid[i] && commit_flush && younger_than(m_cmt[i], a0[5:0])) begin
                m_valid[i] = 1'b0;  // Flush wins over any other update
              end else if (m_valid[i] && m_state[i] == S_DONE && m_cmt[i] == a0[5:0]) begin
                m_state[i] = S_COMMIT;
              end
            end
            next_cycle();
          end
          "DRAIN": begin
            if ($fscanf(fd, "%h %h", a0, a1) != 2) fail_run("Short DRAIN line");
            cnt = 0;
            accepted = 1'b0;
            while (!accepted) begin
              if (cnt == WAIT_LIMIT) fail_run("Timed out waiting for an L1D write");
              if (l1d_wr_valid) begin
                check_value(l1d_wr_paddr, a0, "o_l1d_wr_paddr");
                check_value(l1d_wr_data, a1, "o_l1d_wr_data");
                check_value(l1d_wr_paddr, m_paddr[m_head], "o_l1d_wr_paddr against model");
                check_value(l1d_wr_data, m_data[m_head], "o_l1d_wr_data against model");
                l1d_wr_conflict = rand_conflict ? 1'($random(seed)) : 1'b0;
                if (!l1d_wr_conflict) begin
                  m_valid[m_head] = 1'b0;
                  m_head = (m_head + 1) % STQ_ENTRIES;
                  accepted = 1'b1;
                end
              end
              next_cycle();
              cnt++;
            end
          end
          "CONFLICT": begin
            if ($fscanf(fd, "%s", line) != 1) fail_run("Short CONFLICT line");
            rand_conflict = (line == "RAND");
          end
          "IDLE": begin
            if ($fscanf(fd, "%h", a0) != 1) fail_run("Short IDLE line");
            repeat (a0) next_cycle();
          end
          default: fail_run({"Unknown operation in stimulus file: ", op});
        endcase
      end
    end
    $fclose(fd);
    next_cycle();
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

//--- store_queue.f
design/core_pkg.sv
design/stq_pkg.sv
design/stq_entry_if.sv
design/stq_entry.sv
design/stq_order_ctrl.sv
design/store_queue.sv
sim/tb_clk_gen.sv
sim/tb_store_queue.sv

//--- run_sim.sh
#!/bin/sh
# Build the store queue testbench with Verilator, run it and judge the log

rm -rf obj_dir sim.log build.log
verilator --binary --timing --top-module tb_store_queue -f store_queue.f \
  > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/Vtb_store_queue > sim.log 2>&1
cat sim.log
grep -qx "NO ERRORS" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- sim/store_queue_stim.txt
# DISP cmt rnid data_ready exp_index exp_full | EX1 index hazard paddr data_valid data
# WB rnid data | TLB | RERUN exp_index | COMMIT cmt | FLUSH cmt | DRAIN exp_paddr exp_data
# CONFLICT RAND or NONE | IDLE cycles   (all numbers hex)
DISP 01 11 1 0 0
DISP 02 12 0 1 0
DISP 03 13 1 2 0
DISP 04 14 1 3 0
DISP 05 15 1 0 1
EX1 0 0 00001000 1 aaaa0001
EX1 1 0 00001004 0 00000000
EX1 2 1 00001008 1 aaaa0003
EX1 3 0 0000100c 1 aaaa0004
COMMIT 01
DRAIN 00001000 aaaa0001
# Wrong tag must not wake entry 1
WB 22 bbbb0000
IDLE 2
COMMIT 02
WB 12 bbbb0002
IDLE 1
COMMIT 02
DRAIN 00001004 bbbb0002
TLB
RERUN 2
EX1 2 0 00001018 0 00000000
COMMIT 03
COMMIT 04
DRAIN 00001018 aaaa0003
DRAIN 0000100c aaaa0004
# Flush kills 08 and 09
DISP 06 16 1 0 0
DISP 07 17 1 1 0
DISP 08 18 1 2 0
DISP 09 19 1 3 0
EX1 0 0 00002000 1 cccc0006
EX1 1 0 00002004 1 cccc0007
EX1 2 0 00002008 1 cccc0008
EX1 3 1 0000200c 1 cccc0009
COMMIT 06
FLUSH 07
DISP 0a 1a 1 2 0
TLB
IDLE 1
EX1 2 0 00002010 1 cccc000a
COMMIT 0a
CONFLICT RAND
DRAIN 00002000 cccc0006
DRAIN 00002004 cccc0007
DRAIN 00002010 cccc000a
DISP 0b 1b 1 3 0
DISP 0c 1c 0 0 0
DISP 0d 1d 1 1 0
EX1 3 0 00003000 1 dddd000b
EX1 0 0 00003004 0 00000000
EX1 1 0 00003008 1 dddd000d
WB 1c dddd000c
IDLE 1
COMMIT 0b
COMMIT 0c
COMMIT 0d
DRAIN 00003000 dddd000b
DRAIN 00003004 dddd000c
DRAIN 00003008 dddd000d
CONFLICT NONE
IDLE 2
